// ==== bp_macros.svh ====
////////////////////////////////////////////////////////////////////////////
// Predictor sizes. PC_SIZE must equal BH_SIZE for the hash to line up
// OBQ_DEPTH must be a power of two, with OBQ_PTR_SIZE its log2
////////////////////////////////////////////////////////////////////////////
`ifndef BP_MACROS_SVH
`define BP_MACROS_SVH

// Global history width, also the pattern-table index width
`define BH_SIZE 8

// PC word bits folded into the hash
`define PC_SIZE `BH_SIZE

// Outstanding branch queue
`define OBQ_DEPTH 8
`define OBQ_PTR_SIZE 3 // log2(OBQ_DEPTH)

`endif

// ==== bp_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Shared types of the branch predictor. Widths follow bp_macros.svh
////////////////////////////////////////////////////////////////////////////
`include "bp_macros.svh"

package bp_pkg;

	// Global history, newest outcome in bit 0
	typedef logic [`BH_SIZE-1:0] history_t;

	// Pattern-table index, history XOR PC word bits
	typedef logic [`BH_SIZE-1:0] pht_index_t;

	// Full instruction address
	typedef logic [31:0] pc_t;

	// Queue pointer with one extra wrap bit to tell full from empty
	typedef logic [`OBQ_PTR_SIZE:0] obq_ptr_t;

endpackage

// ==== gshare.sv ====
////////////////////////////////////////////////////////////////////////////
// Gshare with one-bit pattern entries (1 = taken), prediction one cycle late
// Caller must never fire a lookup in a clear cycle, clear always wins here
////////////////////////////////////////////////////////////////////////////
`include "bp_macros.svh"

module gshare (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 lookup_allow,     // Fire condition from the queue
	input  bp_pkg::pc_t          pc_in,
	input  logic                 clear_en,         // Mispredict from the queue
	input  bp_pkg::pht_index_t   rollback_index,   // Entry to flip
	input  bp_pkg::history_t     rollback_history, // Already corrected history
	output logic                 lookup_fire,
	output bp_pkg::pht_index_t   lookup_index,
	output bp_pkg::history_t     lookup_history,
	output logic                 lookup_taken,
	output logic                 prediction_valid,
	output logic                 prediction_out,
	output bp_pkg::history_t     history_out
);

	logic [2**`BH_SIZE-1:0] pht;         // Pattern table, one bit per entry
	bp_pkg::history_t history;           // Global history register
	logic [`PC_SIZE-1:0] pc_word;        // Hashed PC bits
	bp_pkg::pht_index_t hash_index;

	// Byte offset is dropped, only word address bits are hashed
	assign pc_word = pc_in[`PC_SIZE+1:2];
	assign hash_index = history ^ pc_word;

	// Queue already qualified the request
	assign lookup_fire = lookup_allow;

	// Recorded into the queue alongside the push
	assign lookup_index = hash_index;
	assign lookup_history = history;   // Snapshot before the shift
	assign lookup_taken = pht[hash_index];

	assign history_out = history;

	// Table and history
	always_ff @(posedge clock) begin
		if (reset) begin
			pht <= '0;              // All entries start not taken
			history <= '0;
			prediction_valid <= 1'b0;
		end else begin
			prediction_valid <= lookup_fire;
			if (clear_en) begin
				// Wrong guess, invert the entry and restore history
				pht[rollback_index] <= ~pht[rollback_index];
				history <= rollback_history;
			end else if (lookup_fire) begin
				// Speculative update with the guessed direction
				history <= {history[`BH_SIZE-2:0], lookup_taken};
			end
		end
	end

	// Prediction payload, only meaningful with prediction_valid
	always_ff @(posedge clock) begin
		if (lookup_fire) begin
			prediction_out <= lookup_taken;
		end
	end

	// Queue must block lookups during its own clear
	a_no_fire_on_clear: assert property (
		@(posedge clock) disable iff (reset)
		!(clear_en && lookup_fire)
	) else $error("lookup fired during a clear");

endmodule

// ==== branch_queue.sv ====
////////////////////////////////////////////////////////////////////////////
// Outstanding branch queue. Resolves must arrive in program order
// Resolve on empty is ignored, a mispredict flushes all younger entries
////////////////////////////////////////////////////////////////////////////
`include "bp_macros.svh"

module branch_queue (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 enable,
	input  logic                 if_branch,
	input  logic                 lookup_fire,      // Push strobe
	input  bp_pkg::pht_index_t   lookup_index,
	input  bp_pkg::history_t     lookup_history,
	input  logic                 lookup_taken,
	input  logic                 resolve_valid,
	input  logic                 resolve_taken,    // Actual direction
	output logic                 lookup_allow,
	output logic                 clear_en,
	output bp_pkg::pht_index_t   rollback_index,
	output bp_pkg::history_t     rollback_history,
	output logic                 mispredict,
	output logic                 queue_full
);

	// Entry fields, one array each
	bp_pkg::pht_index_t idx_mem [`OBQ_DEPTH];
	bp_pkg::history_t hist_mem [`OBQ_DEPTH];
	logic taken_mem [`OBQ_DEPTH];

	bp_pkg::obq_ptr_t wr_ptr;
	bp_pkg::obq_ptr_t rd_ptr;
	logic [`OBQ_PTR_SIZE-1:0] head;  // Slot of the oldest entry
	logic [`OBQ_PTR_SIZE-1:0] tail;  // Slot for the next push
	logic empty;
	logic full;
	logic resolve_fire;
	logic mismatch;
	bp_pkg::history_t head_history;

	assign head = rd_ptr[`OBQ_PTR_SIZE-1:0];
	assign tail = wr_ptr[`OBQ_PTR_SIZE-1:0];

	// Same slot, wrap bits tell full from empty
	assign empty = (wr_ptr == rd_ptr);
	assign full = (wr_ptr[`OBQ_PTR_SIZE] != rd_ptr[`OBQ_PTR_SIZE]) && (head == tail);
	assign queue_full = full;

	assign resolve_fire = resolve_valid && !empty;        // Empty resolve is dropped
	assign mismatch = resolve_fire && (taken_mem[head] != resolve_taken);

	assign clear_en = mismatch;
	assign mispredict = mismatch;

	// No lookup while full or while rolling back
	assign lookup_allow = enable && if_branch && !full && !mismatch;

	// Rollback data, history gets the real outcome appended
	assign head_history = hist_mem[head];
	assign rollback_index = idx_mem[head];
	assign rollback_history = {head_history[`BH_SIZE-2:0], resolve_taken};

	// Pointers
	always_ff @(posedge clock) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (mismatch) begin
				rd_ptr <= wr_ptr;            // Flush, younger entries are wrong-path
			end else if (resolve_fire) begin
				rd_ptr <= rd_ptr + 1'b1;     // Correct guess, retire head
			end
			if (lookup_fire) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
		end
	end

	// Entry storage
	always_ff @(posedge clock) begin
		if (lookup_fire) begin
			idx_mem[tail] <= lookup_index;
			hist_mem[tail] <= lookup_history;
			taken_mem[tail] <= lookup_taken;
		end
	end

	// Gshare must honour lookup_allow
	a_no_push_full: assert property (
		@(posedge clock) disable iff (reset)
		lookup_fire |-> !full
	) else $error("push into a full queue");

	// Mispredict needs a live head and leaves the queue empty
	a_mispredict_flush: assert property (
		@(posedge clock) disable iff (reset)
		mispredict |-> !empty ##1 empty
	) else $error("mispredict without entry or without flush");

endmodule

// ==== branch_predictor.sv ====
////////////////////////////////////////////////////////////////////////////
// Gshare front end with its outstanding branch queue
// Prediction one cycle after the lookup, lookups dropped when queue_full
////////////////////////////////////////////////////////////////////////////
module branch_predictor (
	input  logic               clock,
	input  logic               reset,
	input  logic               enable,
	input  logic               if_branch,        // Branch at pc_in this cycle
	input  bp_pkg::pc_t        pc_in,
	input  logic               resolve_valid,    // Oldest branch resolved
	input  logic               resolve_taken,
	output logic               prediction_valid,
	output logic               prediction_out,
	output bp_pkg::history_t   history_out,
	output logic               mispredict,
	output logic               queue_full
);

	// Gshare to queue
	logic lookup_fire;
	bp_pkg::pht_index_t lookup_index;
	bp_pkg::history_t lookup_history;
	logic lookup_taken;

	// Queue to gshare
	logic lookup_allow;
	logic clear_en;
	bp_pkg::pht_index_t rollback_index;
	bp_pkg::history_t rollback_history;

	gshare u_gshare (
		.clock            (clock),
		.reset            (reset),
		.lookup_allow     (lookup_allow),
		.pc_in            (pc_in),
		.clear_en         (clear_en),
		.rollback_index   (rollback_index),
		.rollback_history (rollback_history),
		.lookup_fire      (lookup_fire),
		.lookup_index     (lookup_index),
		.lookup_history   (lookup_history),
		.lookup_taken     (lookup_taken),
		.prediction_valid (prediction_valid),
		.prediction_out   (prediction_out),
		.history_out      (history_out)
	);

	branch_queue u_branch_queue (
		.clock            (clock),
		.reset            (reset),
		.enable           (enable),
		.if_branch        (if_branch),
		.lookup_fire      (lookup_fire),
		.lookup_index     (lookup_index),
		.lookup_history   (lookup_history),
		.lookup_taken     (lookup_taken),
		.resolve_valid    (resolve_valid),
		.resolve_taken    (resolve_taken),
		.lookup_allow     (lookup_allow),
		.clear_en         (clear_en),
		.rollback_index   (rollback_index),
		.rollback_history (rollback_history),
		.mispredict       (mispredict),
		.queue_full       (queue_full)
	);

endmodule

// ==== tb_branch_predictor.sv ====
////////////////////////////////////////////////////////////////////////////
// Directed tests of branch_predictor against a cycle-level reference model
// Inputs change 1 ns after the rising edge, combinational outputs read 3 ns after
////////////////////////////////////////////////////////////////////////////
`include "bp_macros.svh"

module tb_branch_predictor;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD = 8;
	localparam int NUM_TESTS = 6;
	localparam int CYCLES_PER_TEST = 200;
	localparam int MARGIN_CYCLES = 500;
	localparam int RANDOM_CYCLES = 300;

	logic clock;
	logic reset;
	logic enable;
	logic if_branch;
	bp_pkg::pc_t pc_in;
	logic resolve_valid;
	logic resolve_taken;
	logic prediction_valid;
	logic prediction_out;
	bp_pkg::history_t history_out;
	logic mispredict;
	logic queue_full;

	// Reference model state
	logic model_pht [2**`BH_SIZE];
	bp_pkg::history_t model_history;
	bp_pkg::pht_index_t q_index [$];
	bp_pkg::history_t q_history [$];
	logic q_taken [$];
	logic last_taken;                 // Pattern bit read by the last lookup

	int error_count = 0;
	int check_count = 0;
	int tests_with_errors = 0;
	logic [31:0] rng_state = 32'he8f5_2432;

	branch_predictor dut (
		.clock            (clock),
		.reset            (reset),
		.enable           (enable),
		.if_branch        (if_branch),
		.pc_in            (pc_in),
		.resolve_valid    (resolve_valid),
		.resolve_taken    (resolve_taken),
		.prediction_valid (prediction_valid),
		.prediction_out   (prediction_out),
		.history_out      (history_out),
		.mispredict       (mispredict),
		.queue_full       (queue_full)
	);

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_random();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	task automatic check_bit(input string what, input logic got, input logic expected);
		check_count++;
		if (got !== expected) begin
			error_count++;
			$display("[ERROR] %0d ns: %s is %b, expected %b", $time, what, got, expected);
		end
	endtask

	task automatic check_history(input string what, input bp_pkg::history_t got,
			input bp_pkg::history_t expected);
		check_count++;
		if (got !== expected) begin
			error_count++;
			$display("[ERROR] %0d ns: %s is %h, expected %h", $time, what, got, expected);
		end
	endtask

	// One clock of stimulus, model update and checks. Entered and left 1 ns after an edge
	task automatic run_cycle(input logic en, input logic br, input bp_pkg::pc_t pc,
			input logic rv, input logic rt);
		logic full_now;
		logic res_fire;
		logic mism;
		logic fire;
		logic taken;
		bp_pkg::pht_index_t idx;
		bp_pkg::history_t old_history;
		enable = en;
		if_branch = br;
		pc_in = pc;
		resolve_valid = rv;
		resolve_taken = rt;
		full_now = (q_taken.size() == `OBQ_DEPTH);
		res_fire = rv && (q_taken.size() > 0);                 // Empty resolve ignored
		mism = res_fire && (q_taken[0] != rt);
		fire = en && br && !full_now && !mism;
		idx = model_history ^ pc[`PC_SIZE+1:2];                // Word bits only
		taken = model_pht[idx];
		old_history = model_history;
		#2;
		check_bit("mispredict", mispredict, mism);
		check_bit("queue_full", queue_full, full_now);
		if (mism) begin
			// Flip the stored entry, rebuild history, flush everything younger
			model_pht[q_index[0]] = ~model_pht[q_index[0]];
			model_history = {q_history[0][`BH_SIZE-2:0], rt};
			q_index.delete();
			q_history.delete();
			q_taken.delete();
		end else begin
			if (res_fire) begin
				void'(q_index.pop_front());
				void'(q_history.pop_front());
				void'(q_taken.pop_front());
			end
			if (fire) begin
				q_index.push_back(idx);
				q_history.push_back(old_history);
				q_taken.push_back(taken);
				model_history = {old_history[`BH_SIZE-2:0], taken};
			end
		end
		@(posedge clock);
		#1;
		check_bit("prediction_valid", prediction_valid, fire);
		if (fire)
			check_bit("prediction_out", prediction_out, taken);
		check_history("history_out", history_out, model_history);
		check_bit("queue_full", queue_full, q_taken.size() == `OBQ_DEPTH);
		last_taken = taken;
	endtask

	// Resolve every outstanding branch with its predicted direction
	task automatic drain_queue();
		while (q_taken.size() > 0)
			run_cycle(1'b0, 1'b0, '0, 1'b1, q_taken[0]);
	endtask

	task automatic report_test(input string name, input int errors_before);
		int errs;
		errs = error_count - errors_before;
		if (errs != 0)
			tests_with_errors++;
		$display("[%0d ns] %-20s done, %0d errors", $time, name, errs);
	endtask

	task automatic reset_values();
		int errs;
		errs = error_count;
		check_bit("prediction_valid after reset", prediction_valid, 1'b0);
		check_bit("mispredict after reset", mispredict, 1'b0);
		check_bit("queue_full after reset", queue_full, 1'b0);
		check_history("history_out after reset", history_out, '0);
		run_cycle(1'b1, 1'b1, next_random(), 1'b0, 1'b0);
		check_bit("first prediction", prediction_out, 1'b0);   // Table starts not taken
		report_test("reset_values", errs);
	endtask

	task automatic lookup_path();
		int errs;
		bp_pkg::history_t h;
		errs = error_count;
		h = model_history;
		run_cycle(1'b1, 1'b1, next_random(), 1'b0, 1'b0);
		check_bit("prediction_valid after lookup", prediction_valid, 1'b1);
		check_history("shifted history", history_out, {h[`BH_SIZE-2:0], last_taken});
		run_cycle(1'b0, 1'b1, next_random(), 1'b0, 1'b0);  // Enable low
		check_bit("prediction_valid with enable low", prediction_valid, 1'b0);
		run_cycle(1'b1, 1'b0, next_random(), 1'b0, 1'b0);  // No branch strobe
		report_test("lookup_path", errs);
	endtask

	task automatic correct_resolve();
		int errs;
		bp_pkg::history_t h;
		errs = error_count;
		drain_queue();
		run_cycle(1'b1, 1'b1, next_random(), 1'b0, 1'b0);
		h = model_history;
		run_cycle(1'b0, 1'b0, '0, 1'b1, q_taken[0]);
		check_history("history after correct resolve", history_out, h);
		run_cycle(1'b1, 1'b1, next_random(), 1'b0, 1'b0);
		run_cycle(1'b1, 1'b1, next_random(), 1'b0, 1'b0);
		run_cycle(1'b1, 1'b1, next_random(), 1'b1, q_taken[0]);  // Pop and push together
		check_bit("prediction_valid with pop", prediction_valid, 1'b1);
		drain_queue();    // Wrong queue contents would show up as mispredicts here
		report_test("correct_resolve", errs);
	endtask

	task automatic mispredict_recovery();
		int errs;
		bp_pkg::history_t h0;
		bp_pkg::pc_t pc;
		bp_pkg::pc_t pc_same;
		bp_pkg::pht_index_t idx;
		logic p;
		errs = error_count;
		drain_queue();
		pc = next_random();
		h0 = model_history;
		idx = h0 ^ pc[`PC_SIZE+1:2];
		run_cycle(1'b1, 1'b1, pc, 1'b0, 1'b0);
		p = last_taken;
		run_cycle(1'b1, 1'b1, next_random(), 1'b1, ~p);   // Lookup in the same cycle is blocked
		check_bit("prediction_valid in mispredict cycle", prediction_valid, 1'b0);
		check_history("corrected history", history_out, {h0[`BH_SIZE-2:0], ~p});
		// Pick a PC whose hash lands on the flipped entry again
		pc_same = pc;
		pc_same[`PC_SIZE+1:2] = idx ^ model_history;
		run_cycle(1'b1, 1'b1, pc_same, 1'b0, 1'b0);
		check_bit("flipped prediction", prediction_out, ~p);
		drain_queue();
		report_test("mispredict_recovery", errs);
	endtask

	task automatic back_pressure();
		int errs;
		errs = error_count;
		drain_queue();
		repeat (`OBQ_DEPTH)
			run_cycle(1'b1, 1'b1, next_random(), 1'b0, 1'b0);
		check_bit("queue_full after filling", queue_full, 1'b1);
		run_cycle(1'b1, 1'b1, next_random(), 1'b0, 1'b0);
		check_bit("prediction_valid while full", prediction_valid, 1'b0);
		run_cycle(1'b0, 1'b0, '0, 1'b1, q_taken[0]);     // Still full during the pop
		check_bit("queue_full after one resolve", queue_full, 1'b0);
		drain_queue();
		report_test("back_pressure", errs);
	endtask

	task automatic random_traffic();
		int errs;
		logic [31:0] r;
		errs = error_count;
		repeat (RANDOM_CYCLES) begin
			r = next_random();
			// Enable high three times in four, resolves one cycle in four
			run_cycle(r[0] | r[1], r[2], next_random(), r[3] & r[4], r[5]);
		end
		drain_queue();
		report_test("random_traffic", errs);
	endtask

	// Bound on run time, tests normally end well inside it
	initial begin
		#((NUM_TESTS * CYCLES_PER_TEST + MARGIN_CYCLES) * CLK_PERIOD);
		$display("Timeout: tests did not finish within %0d ns",
			(NUM_TESTS * CYCLES_PER_TEST + MARGIN_CYCLES) * CLK_PERIOD);
		$display("Simulation FAILED");
		$finish;
	end

	initial begin
		reset = 1'b1;
		enable = 1'b0;
		if_branch = 1'b0;
		pc_in = '0;
		resolve_valid = 1'b0;
		resolve_taken = 1'b0;
		last_taken = 1'b0;
		for (int i = 0; i < 2**`BH_SIZE; i++)
			model_pht[i] = 1'b0;
		model_history = '0;
		repeat (8) @(posedge clock);
		#1;
		reset = 1'b0;
		reset_values();
		lookup_path();
		correct_resolve();
		mispredict_recovery();
		back_pressure();
		random_traffic();
		$display("Tests run %0d, with errors %0d, checks %0d, errors %0d",
			NUM_TESTS, tests_with_errors, check_count, error_count);
		if (error_count == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

// ==== tb.f ====
+incdir+.
bp_pkg.sv
gshare.sv
branch_queue.sv
branch_predictor.sv
tb_branch_predictor.sv

// ==== Makefile ====
# Verilator flow for the branch predictor
# Override on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_branch_predictor
LOG       ?= sim.log
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Simulation PASSED" $(LOG); then \
		echo "Run passed, log in $(LOG)"; \
	else \
		echo "Run failed, log in $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
